//--- dv/decode_assert.sv
`include "decode_consts.svh"

module decode_assert (
   input logic               clk,
   input logic               rstN,
   input decode_pkg::wordT   instruction,
   input logic               writeEn,
   input decode_pkg::regSelT writeReg,
   input decode_pkg::wordT   writeData,
   input decode_pkg::wordT   readData1,
   input decode_pkg::wordT   readData2,
   input decode_pkg::wordT   imm5Ext,
   input decode_pkg::wordT   imm8Ext,
   input decode_pkg::wordT   imm11Ext,
   input logic               err,
   input logic               halt,
   input logic               regWrite,
   input logic               memWrite,
   input logic               memEnable
);
   timeunit 1ns;
   timeprecision 1ps;
   import decode_pkg::*;

   int failCount = 0;                              // Read by the testbench at the end

   // Bits above the field all zero or all one
   function automatic logic uniform(wordT v, int width);
      return ((v >> width) == '0) || ((v >> width) == ({`DATA_WIDTH{1'b1}} >> width));
   endfunction

   bypass1A: assert property (@(posedge clk) disable iff (!rstN)
      (writeEn && writeReg == instruction[`RS1_MSB:`RS1_LSB]) |-> (readData1 == writeData))
      else begin
         $error("Read port 1 did not forward the write data");
         failCount++;
      end

   bypass2A: assert property (@(posedge clk) disable iff (!rstN)
      (writeEn && writeReg == instruction[`RS2_MSB:`RS2_LSB]) |-> (readData2 == writeData))
      else begin
         $error("Read port 2 did not forward the write data");
         failCount++;
      end

   immUniformA: assert property (@(posedge clk) disable iff (!rstN)
      uniform(imm5Ext, `IMM5_WIDTH) && uniform(imm8Ext, `IMM8_WIDTH)
      && uniform(imm11Ext, `IMM11_WIDTH))
      else begin
         $error("Extended immediate has mixed upper bits");
         failCount++;
      end

   illegalA: assert property (@(posedge clk) disable iff (!rstN)
      err |-> (!regWrite && !memWrite && !memEnable))  // No side effects
      else begin
         $error("Illegal opcode left a write or memory strobe high");
         failCount++;
      end

   haltA: assert property (@(posedge clk) disable iff (!rstN)
      halt == (instruction[`OPCODE_MSB:`OPCODE_LSB] == OP_HALT))
      else begin
         $error("halt does not match the HALT opcode");
         failCount++;
      end

endmodule

bind decode decode_assert u_decodeAssert (.*);

//--- dv/decode_tb.sv
`include "decode_consts.svh"

module decode_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import decode_pkg::*;

   localparam int RW_PAIRS   = 200;
   localparam int NUM_BYPASS = 16;
   localparam int IMM_REPS   = 4;
   localparam int OP_REPS    = 2;
   localparam int CYCLE_LIMIT = 2 * (5 + `NUM_REGS + 2 * RW_PAIRS + NUM_BYPASS
                                     + 17 * IMM_REPS + 32 * OP_REPS);

   logic      clk = 1'b0;
   logic      rstN;
   wordT      instruction;
   wordT      writeData;
   logic      writeEn;
   regSelT    writeReg;
   wordT      pcUpdated;
   logic      immSrc, aluJump, potRaw, invA, invB, cin, beq, bne, blt, bgt;
   logic      regWrite, memEnable, memWrite, memRead, halt, err;
   memToRegE  memToReg;
   srcSelE    aluSrc1, aluSrc2;
   aluOpE     aluOp;
   wordT      readData1, readData2, imm5Ext, imm8Ext, imm11Ext;
   regSelT    writeRegister;

   wordT      refRegs [`NUM_REGS];                 // Reference register file
   string     curTest;
   int        testErrs;
   int        errCount = 0;
   int        testsRun = 0;
   int        testsFailed = 0;
   int        cycles = 0;

   opcodeE    immOps [17] = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD, OP_ST, OP_STU,
                              OP_LBI, OP_SLBI, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_J,
                              OP_JR, OP_JAL, OP_JALR};
   aluOpE     aluFuncOps [4]   = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN};  // By func
   aluOpE     shiftFuncOps [4] = '{ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL};

   decode i_dut (.*);

   always #10 clk = ~clk;                          // 20 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic wordT randWord();
      logic [31:0] r;
      r = $urandom();
      return r[`DATA_WIDTH-1:0];
   endfunction

   function automatic wordT regInstr(regSelT rs1, regSelT rs2);
      return {OP_NOP, rs1, rs2, 5'b00000};        // Only the read selects matter
   endfunction

   function automatic logic isLegal(logic [4:0] op);
      case (op)
         OP_HALT, OP_NOP, OP_J, OP_JR, OP_JAL, OP_JALR, OP_ADDI, OP_SUBI, OP_XORI,
         OP_ANDNI, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_ST, OP_LD, OP_SLBI, OP_STU,
         OP_LBI, OP_SHIFT, OP_ALU, OP_SEQ, OP_SLT, OP_SLE, OP_SCO: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // ALU function of each instruction, func picks within the R groups
   function automatic aluOpE expAluOp(logic [4:0] op, logic [1:0] func);
      case (op)
         OP_SUBI:  return ALU_SUB;
         OP_XORI:  return ALU_XOR;
         OP_ANDNI: return ALU_ANDN;
         OP_LBI:   return ALU_PASSB;
         OP_SLBI:  return ALU_SLBI;
         OP_ALU:   return aluFuncOps[func];
         OP_SHIFT: return shiftFuncOps[func];
         OP_SEQ:   return ALU_SEQ;
         OP_SLT:   return ALU_SLT;
         OP_SLE:   return ALU_SLE;
         OP_SCO:   return ALU_SCO;
         default:  return ALU_ADD;                 // Address adds and no-ops
      endcase
   endfunction

   // Field of the given width at bit 0, zero or sign filled
   function automatic wordT extend(wordT instr, int width, logic zero);
      wordT mask;
      mask = wordT'((32'h1 << width) - 1);
      if (!zero && instr[width-1])
         return instr | ~mask;
      return instr & mask;
   endfunction

   function automatic wordT expRead(regSelT sel);
      return (writeEn && writeReg == sel) ? writeData : refRegs[sel];  // Bypass first
   endfunction

   task automatic step(wordT instr, logic wEn, regSelT wReg, wordT wData);
      @(posedge clk);
      instruction <= instr;
      writeEn     <= wEn;
      writeReg    <= wReg;
      writeData   <= wData;
      pcUpdated   <= randWord();
      @(negedge clk);                              // Outputs settled
   endtask

   task automatic check(string what, wordT expected, wordT actual);
      if (expected !== actual) begin
         $display("** Error %s %s: expected %h, actual %h", curTest, what, expected, actual);
         testErrs++;
      end
   endtask

   task automatic checkReads();
      check("readData1", expRead(instruction[`RS1_MSB:`RS1_LSB]), readData1);
      check("readData2", expRead(instruction[`RS2_MSB:`RS2_LSB]), readData2);
      if (writeEn)
         refRegs[writeReg] = writeData;            // Stored at the coming edge
   endtask

   task automatic checkOpcode(logic [4:0] op);
      wordT     w;
      wordT     instr;
      logic     legal;
      logic     wr;
      regSelT   dst;
      logic [1:0] func;
      logic     sub;
      logic     cmp;
      memToRegE wb;
      srcSelE   src1;
      srcSelE   src2;
      w = randWord();
      instr = {op, w[10:0]};
      func = instr[`FUNC_MSB:`FUNC_LSB];
      legal = isLegal(op);
      wr = legal && !(op inside {OP_ST, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_J, OP_JR,
                                 OP_HALT, OP_NOP});
      if (op inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD})
         dst = instr[7:5];
      else if (op inside {OP_LBI, OP_SLBI, OP_STU})
         dst = instr[10:8];
      else if (op inside {OP_JAL, OP_JALR})
         dst = 3'd7;                               // Link register
      else
         dst = instr[4:2];
      sub = (op == OP_SUBI) || (op == OP_ALU && func == 2'b01);  // ~A + 1
      cmp = op inside {OP_SEQ, OP_SLT, OP_SLE};                  // A + ~B + 1
      wb = WB_ALU;
      if (op == OP_LD)
         wb = WB_MEM;
      else if (op inside {OP_JAL, OP_JALR})
         wb = WB_PC2;
      src1 = SRC_REG;
      if (op inside {OP_J, OP_JAL})
         src1 = SRC_PC;                            // PC-relative target
      src2 = SRC_REG;
      if (op inside {OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ})
         src2 = SRC_ZERO;
      else if (op inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD, OP_ST, OP_STU, OP_LBI,
                          OP_SLBI, OP_J, OP_JAL, OP_JR, OP_JALR})
         src2 = SRC_IMM;
      step(instr, 1'b0, '0, '0);
      check("err", 16'(!legal), 16'(err));
      check("regWrite", 16'(wr), 16'(regWrite));
      check("memWrite", 16'(op inside {OP_ST, OP_STU}), 16'(memWrite));
      check("memRead", 16'(op == OP_LD), 16'(memRead));
      check("halt", 16'(op == OP_HALT), 16'(halt));
      check("memEnable", 16'(op inside {OP_LD, OP_ST, OP_STU}), 16'(memEnable));
      check("immSrc", 16'(op inside {OP_LBI, OP_SLBI, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
                                     OP_JR, OP_JALR}), 16'(immSrc));
      check("aluJump", 16'(op inside {OP_J, OP_JR, OP_JAL, OP_JALR}), 16'(aluJump));
      check("potRaw", 16'(legal && !(op inside {OP_HALT, OP_NOP, OP_LBI, OP_J, OP_JAL})),
            16'(potRaw));
      check("invA", 16'(sub), 16'(invA));
      check("invB", 16'(cmp || op == OP_ANDNI || (op == OP_ALU && func == 2'b11)),
            16'(invB));
      check("cin", 16'(sub || cmp), 16'(cin));
      check("beq", 16'(op == OP_BEQZ), 16'(beq));
      check("bne", 16'(op == OP_BNEZ), 16'(bne));
      check("blt", 16'(op == OP_BLTZ), 16'(blt));
      check("bgt", 16'(op == OP_BGEZ), 16'(bgt));
      check("memToReg", 16'(wb), 16'(memToReg));
      check("aluSrc1", 16'(src1), 16'(aluSrc1));
      check("aluSrc2", 16'(src2), 16'(aluSrc2));
      check("aluOp", 16'(expAluOp(op, func)), 16'(aluOp));
      if (wr)
         check("writeRegister", 16'(dst), 16'(writeRegister));
   endtask

   task automatic beginTest(string name);
      curTest = name;
      testErrs = 0;
   endtask

   task automatic endTest();
      testsRun++;
      errCount += testErrs;
      if (testErrs != 0)
         testsFailed++;
      $display("test %s %s, %0d mismatches", curTest, testErrs == 0 ? "passed" : "failed",
               testErrs);
   endtask

   initial begin
      logic [31:0] r;
      logic        zx;
      void'($urandom(32'h7125));
      rstN        = 1'b0;
      instruction = '0;
      writeData   = '0;
      writeEn     = 1'b0;
      writeReg    = '0;
      pcUpdated   = '0;
      foreach (refRegs[i])
         refRegs[i] = '0;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;                                // Low through two full cycles

      beginTest("reset");
      for (int i = 0; i < `NUM_REGS; i++) begin
         step(regInstr(i[2:0], 3'(`NUM_REGS - 1 - i)), 1'b0, '0, '0);
         checkReads();
      end
      endTest();

      beginTest("regfile");
      repeat (RW_PAIRS) begin
         r = $urandom();
         step(regInstr(r[2:0], r[5:3]), 1'b1, r[8:6], randWord());
         checkReads();
         step(regInstr(r[11:9], r[14:12]), 1'b0, '0, '0);  // Read back
         checkReads();
      end
      endTest();

      beginTest("bypass");
      repeat (NUM_BYPASS) begin
         r = $urandom();
         step(regInstr(r[2:0], r[5:3]), 1'b1, r[2:0], randWord());  // Port 1 hits
         check("bypass", writeData, readData1);
         checkReads();
      end
      endTest();

      beginTest("immediates");
      foreach (immOps[k]) begin
         repeat (IMM_REPS) begin
            r = $urandom();
            step({immOps[k], r[10:0]}, 1'b0, '0, '0);
            zx = immOps[k] inside {OP_XORI, OP_ANDNI, OP_SLBI};
            check("imm5Ext", extend(instruction, `IMM5_WIDTH, zx), imm5Ext);
            check("imm8Ext", extend(instruction, `IMM8_WIDTH, zx), imm8Ext);
            check("imm11Ext", extend(instruction, `IMM11_WIDTH, 1'b0), imm11Ext);
         end
      end
      endTest();

      beginTest("strobes");
      for (int o = 0; o < 32; o++) begin
         if (isLegal(o[4:0])) begin
            repeat (OP_REPS) checkOpcode(o[4:0]);
         end
      end
      endTest();

      beginTest("illegal");
      for (int o = 0; o < 32; o++) begin
         if (!isLegal(o[4:0])) begin
            repeat (OP_REPS) checkOpcode(o[4:0]);
         end
      end
      endTest();

      @(posedge clk);                              // Let the last assertions sample
      @(negedge clk);
      if (i_dut.u_decodeAssert.failCount != 0)
         $display("Checker assertions failed %0d times", i_dut.u_decodeAssert.failCount);
      $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures", testsRun,
               testsFailed, errCount, i_dut.u_decodeAssert.failCount);
      if (errCount == 0 && i_dut.u_decodeAssert.failCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+hw
hw/decode_pkg.sv
hw/control.sv
hw/regFileBypass.sv
hw/decode.sv
dv/decode_assert.sv
dv/decode_tb.sv

//--- hw/control.sv
`include "decode_consts.svh"

module control (
   input  decode_pkg::opcodeE                opcode,
   input  logic [`FUNC_MSB-`FUNC_LSB:0]      func,
   output logic                              zeroExt,   // Zero-extend imm5/imm8
   output logic                              immSrc,    // ALU immediate, 0 imm5, 1 imm8
   output logic                              regWrite,
   output logic                              memEnable,
   output logic                              memWrite,
   output logic                              memRead,
   output logic                              aluJump,   // Next PC from ALU result
   output logic                              potRaw,    // Reads a source register
   output logic                              invA,
   output logic                              invB,
   output logic                              cin,
   output logic                              beq,
   output logic                              bne,
   output logic                              blt,
   output logic                              bgt,
   output logic                              halt,
   output logic                              err,       // Opcode not implemented
   output decode_pkg::regDstE                regDst,
   output decode_pkg::memToRegE              memToReg,
   output decode_pkg::srcSelE                aluSrc1,
   output decode_pkg::srcSelE                aluSrc2,
   output decode_pkg::aluOpE                 aluOp
);
   import decode_pkg::*;

   always_comb begin
      zeroExt   = 1'b0;                             // Defaults describe a NOP
      immSrc    = 1'b0;
      regWrite  = 1'b0;
      memEnable = 1'b0;
      memWrite  = 1'b0;
      memRead   = 1'b0;
      aluJump   = 1'b0;
      potRaw    = 1'b0;
      invA      = 1'b0;
      invB      = 1'b0;
      cin       = 1'b0;
      beq       = 1'b0;
      bne       = 1'b0;
      blt       = 1'b0;
      bgt       = 1'b0;
      halt      = 1'b0;
      err       = 1'b0;
      regDst    = RD_RS2;
      memToReg  = WB_ALU;
      aluSrc1   = SRC_REG;
      aluSrc2   = SRC_REG;
      aluOp     = ALU_ADD;

      case (opcode)
         OP_HALT: begin
            halt = 1'b1;                            // Stops fetch at retire
         end
         OP_NOP: begin
            // Nothing beyond the defaults
         end
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            regWrite = 1'b1;                        // Rd in bits 7:5
            potRaw   = 1'b1;
            aluSrc2  = SRC_IMM;
            case (opcode)
               OP_SUBI: begin
                  aluOp = ALU_SUB;                  // imm - Rs
                  invA  = 1'b1;
                  cin   = 1'b1;
               end
               OP_XORI: begin
                  aluOp   = ALU_XOR;
                  zeroExt = 1'b1;                   // Logical ops take unsigned imm
               end
               OP_ANDNI: begin
                  aluOp   = ALU_ANDN;
                  invB    = 1'b1;                   // A & ~imm
                  zeroExt = 1'b1;
               end
               default: aluOp = ALU_ADD;
            endcase
         end
         OP_LD: begin
            regWrite  = 1'b1;
            memEnable = 1'b1;
            memRead   = 1'b1;
            memToReg  = WB_MEM;
            potRaw    = 1'b1;                       // Base register
            aluSrc2   = SRC_IMM;                    // Rs + imm5
         end
         OP_ST, OP_STU: begin
            memEnable = 1'b1;
            memWrite  = 1'b1;
            potRaw    = 1'b1;                       // Base and store data
            aluSrc2   = SRC_IMM;
            if (opcode == OP_STU) begin
               regWrite = 1'b1;                     // Base gets the address
               regDst   = RD_RS1;
            end
         end
         OP_LBI: begin
            regWrite = 1'b1;
            regDst   = RD_RS1;
            immSrc   = 1'b1;
            aluSrc2  = SRC_IMM;
            aluOp    = ALU_PASSB;                   // Signed imm8 into Rs
         end
         OP_SLBI: begin
            regWrite = 1'b1;
            regDst   = RD_RS1;
            potRaw   = 1'b1;
            zeroExt  = 1'b1;                        // Low byte is raw
            immSrc   = 1'b1;
            aluSrc2  = SRC_IMM;
            aluOp    = ALU_SLBI;
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            potRaw  = 1'b1;                         // Rs vs zero
            immSrc  = 1'b1;                         // imm8 offset
            aluSrc2 = SRC_ZERO;                     // Rs passes the adder
            beq     = (opcode == OP_BEQZ);
            bne     = (opcode == OP_BNEZ);
            blt     = (opcode == OP_BLTZ);
            bgt     = (opcode == OP_BGEZ);
         end
         OP_J, OP_JAL: begin
            aluJump = 1'b1;
            aluSrc1 = SRC_PC;                       // PC+2 + imm11
            aluSrc2 = SRC_IMM;
            if (opcode == OP_JAL) begin
               regWrite = 1'b1;
               regDst   = RD_R7;
               memToReg = WB_PC2;                   // Link address
            end
         end
         OP_JR, OP_JALR: begin
            aluJump = 1'b1;
            potRaw  = 1'b1;
            immSrc  = 1'b1;                         // Rs + imm8
            aluSrc2 = SRC_IMM;
            if (opcode == OP_JALR) begin
               regWrite = 1'b1;
               regDst   = RD_R7;
               memToReg = WB_PC2;
            end
         end
         OP_ALU: begin
            regWrite = 1'b1;
            regDst   = RD_RD;
            potRaw   = 1'b1;
            case (func)
               2'b00: aluOp = ALU_ADD;
               2'b01: begin
                  aluOp = ALU_SUB;                  // Rt - Rs
                  invA  = 1'b1;
                  cin   = 1'b1;
               end
               2'b10: aluOp = ALU_XOR;
               default: begin
                  aluOp = ALU_ANDN;
                  invB  = 1'b1;
               end
            endcase
         end
         OP_SHIFT: begin
            regWrite = 1'b1;
            regDst   = RD_RD;
            potRaw   = 1'b1;
            case (func)                             // Amount from Rt
               2'b00:   aluOp = ALU_ROL;
               2'b01:   aluOp = ALU_SLL;
               2'b10:   aluOp = ALU_ROR;
               default: aluOp = ALU_SRL;
            endcase
         end
         OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
            regWrite = 1'b1;
            regDst   = RD_RD;
            potRaw   = 1'b1;
            if (opcode != OP_SCO) begin
               invB = 1'b1;                         // Compare via Rs - Rt
               cin  = 1'b1;
            end
            case (opcode)
               OP_SEQ:  aluOp = ALU_SEQ;
               OP_SLT:  aluOp = ALU_SLT;
               OP_SLE:  aluOp = ALU_SLE;
               default: aluOp = ALU_SCO;            // Carry of Rs + Rt
            endcase
         end
         default: begin
            err = 1'b1;                             // Strobes stay at defaults
         end
      endcase
   end

endmodule

//--- hw/decode.sv
`include "decode_consts.svh"

module decode (
   input  logic                   clk,
   input  logic                   rstN,
   input  decode_pkg::wordT       instruction,
   input  decode_pkg::wordT       writeData,     // From write-back
   input  logic                   writeEn,
   input  decode_pkg::regSelT     writeReg,
   input  decode_pkg::wordT       pcUpdated,     // PC+2 of this instruction
   output logic                   immSrc,
   output logic                   regWrite,
   output logic                   memEnable,
   output logic                   memWrite,
   output logic                   memRead,
   output logic                   aluJump,
   output logic                   potRaw,
   output logic                   invA,
   output logic                   invB,
   output logic                   cin,
   output logic                   beq,
   output logic                   bne,
   output logic                   blt,
   output logic                   bgt,
   output logic                   halt,
   output logic                   err,
   output decode_pkg::memToRegE   memToReg,
   output decode_pkg::srcSelE     aluSrc1,
   output decode_pkg::srcSelE     aluSrc2,
   output decode_pkg::aluOpE      aluOp,
   output decode_pkg::wordT       readData1,
   output decode_pkg::wordT       readData2,
   output decode_pkg::wordT       imm5Ext,
   output decode_pkg::wordT       imm8Ext,
   output decode_pkg::wordT       imm11Ext,
   output decode_pkg::regSelT     writeRegister
);
   import decode_pkg::*;

   logic                      zeroExt;           // Consumed here only
   regDstE                    regDst;
   logic [`IMM5_WIDTH-1:0]    imm5;
   logic [`IMM8_WIDTH-1:0]    imm8;
   logic [`IMM11_WIDTH-1:0]   imm11;
   logic                      imm5Fill;
   logic                      imm8Fill;

   control u_control (
      .opcode    (opcodeE'(instruction[`OPCODE_MSB:`OPCODE_LSB])),
      .func      (instruction[`FUNC_MSB:`FUNC_LSB]),
      .zeroExt   (zeroExt),
      .immSrc    (immSrc),
      .regWrite  (regWrite),
      .memEnable (memEnable),
      .memWrite  (memWrite),
      .memRead   (memRead),
      .aluJump   (aluJump),
      .potRaw    (potRaw),
      .invA      (invA),
      .invB      (invB),
      .cin       (cin),
      .beq       (beq),
      .bne       (bne),
      .blt       (blt),
      .bgt       (bgt),
      .halt      (halt),
      .err       (err),                          // Only error source
      .regDst    (regDst),
      .memToReg  (memToReg),
      .aluSrc1   (aluSrc1),
      .aluSrc2   (aluSrc2),
      .aluOp     (aluOp)
   );

   regFileBypass u_regFile (
      .clk       (clk),
      .rstN      (rstN),
      .read1Sel  (instruction[`RS1_MSB:`RS1_LSB]),
      .read2Sel  (instruction[`RS2_MSB:`RS2_LSB]),
      .writeReg  (writeReg),
      .writeEn   (writeEn),
      .writeData (writeData),
      .read1Data (readData1),
      .read2Data (readData2)
   );

   // Immediate fields sit right aligned
   assign imm5  = instruction[`IMM5_WIDTH-1:0];
   assign imm8  = instruction[`IMM8_WIDTH-1:0];
   assign imm11 = instruction[`IMM11_WIDTH-1:0];

   // Fill bit is the sign unless zero extension is asked for
   assign imm5Fill = ~zeroExt & imm5[`IMM5_WIDTH-1];
   assign imm8Fill = ~zeroExt & imm8[`IMM8_WIDTH-1];

   assign imm5Ext  = {{(`DATA_WIDTH-`IMM5_WIDTH){imm5Fill}}, imm5};
   assign imm8Ext  = {{(`DATA_WIDTH-`IMM8_WIDTH){imm8Fill}}, imm8};
   assign imm11Ext = {{(`DATA_WIDTH-`IMM11_WIDTH){imm11[`IMM11_WIDTH-1]}}, imm11}; // Always signed

   // Destination register by format
   always_comb begin
      case (regDst)
         RD_RS2:  writeRegister = instruction[`RS2_MSB:`RS2_LSB]; // I-format 1
         RD_RS1:  writeRegister = instruction[`RS1_MSB:`RS1_LSB]; // LBI, SLBI, STU
         RD_RD:   writeRegister = instruction[`RD_MSB:`RD_LSB];   // R-format
         default: writeRegister = regSelT'(`NUM_REGS - 1);        // Link to R7
      endcase
   end

endmodule

//--- hw/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath sizes
`define DATA_WIDTH    16 // Machine word
`define NUM_REGS      8  // R0..R7
`define REG_SEL_WIDTH 3  // Register number

// Instruction field positions
`define OPCODE_MSB 15
`define OPCODE_LSB 11
`define RS1_MSB    10 // Rs, first read port
`define RS1_LSB    8
`define RS2_MSB    7  // Rt, or Rd of I-format 1
`define RS2_LSB    5
`define RD_MSB     4  // Rd of R-format
`define RD_LSB     2
`define FUNC_MSB   1  // ALU/shift function select
`define FUNC_LSB   0

// Immediate field widths, all right aligned in the word
`define IMM5_WIDTH  5
`define IMM8_WIDTH  8
`define IMM11_WIDTH 11

// Encoded control field widths
`define ALU_OP_WIDTH 4
`define SEL_WIDTH    2 // regDst, memToReg, ALU sources

`endif

//--- hw/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

   typedef logic [`DATA_WIDTH-1:0]    wordT;   // Register and bus word
   typedef logic [`REG_SEL_WIDTH-1:0] regSelT; // Register number

   // Implemented opcodes, anything else is illegal
   typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100, // PC-relative, imm11
      OP_JR    = 5'b00101, // Rs + imm8
      OP_JAL   = 5'b00110,
      OP_JALR  = 5'b00111,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001, // Rd = imm - Rs
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_BLTZ  = 5'b01110,
      OP_BGEZ  = 5'b01111,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_SLBI  = 5'b10010, // Rs = (Rs << 8) | imm8
      OP_STU   = 5'b10011, // Store, then Rs = address
      OP_LBI   = 5'b11000,
      OP_SHIFT = 5'b11010, // ROL/SLL/ROR/SRL by func
      OP_ALU   = 5'b11011, // ADD/SUB/XOR/ANDN by func
      OP_SEQ   = 5'b11100,
      OP_SLT   = 5'b11101,
      OP_SLE   = 5'b11110,
      OP_SCO   = 5'b11111  // Set on carry out
   } opcodeE;

   typedef enum logic [`ALU_OP_WIDTH-1:0] {
      ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN,
      ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
      ALU_PASSB, // Operand B straight through
      ALU_SLBI,
      ALU_SEQ, ALU_SLT, ALU_SLE, ALU_SCO
   } aluOpE;

   // Write register field, encoding matches the decode mux
   typedef enum logic [`SEL_WIDTH-1:0] {
      RD_RS2 = 2'b00, // Bits 7:5
      RD_RS1 = 2'b01, // Bits 10:8
      RD_RD  = 2'b10, // Bits 4:2
      RD_R7  = 2'b11  // Link register
   } regDstE;

   typedef enum logic [`SEL_WIDTH-1:0] {
      WB_ALU, WB_MEM, WB_PC2, WB_IMM
   } memToRegE;

   // Shared by both ALU operand muxes
   typedef enum logic [`SEL_WIDTH-1:0] {
      SRC_REG, SRC_IMM, SRC_PC, SRC_ZERO
   } srcSelE;

endpackage

//--- hw/regFileBypass.sv
`include "decode_consts.svh"

module regFileBypass (
   input  logic               clk,
   input  logic               rstN,
   input  decode_pkg::regSelT read1Sel,
   input  decode_pkg::regSelT read2Sel,
   input  decode_pkg::regSelT writeReg,
   input  logic               writeEn,
   input  decode_pkg::wordT   writeData,
   output decode_pkg::wordT   read1Data,
   output decode_pkg::wordT   read2Data
);
   import decode_pkg::*;

   wordT regs [`NUM_REGS];                         // R0 is an ordinary register
   logic hit1;
   logic hit2;

   // Storage, written at the edge that ends the write-back cycle
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeReg] <= writeData;
      end
   end

   // Same-cycle forwarding of the write port
   assign hit1 = writeEn && (writeReg == read1Sel);
   assign hit2 = writeEn && (writeReg == read2Sel);

   assign read1Data = hit1 ? writeData : regs[read1Sel];  // Rs
   assign read2Data = hit2 ? writeData : regs[read2Sel];  // Rt

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it and judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module decode_tb -o decode_sim

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/decode_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^TEST OK$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
